// ==== verilog/stream_bridge_config.svh ====
`ifndef STREAM_BRIDGE_CONFIG_SVH
`define STREAM_BRIDGE_CONFIG_SVH

////////////////////////////////////////////////////////////
// FIFO geometry
////////////////////////////////////////////////////////////
`define BRIDGE_FIFO_DEPTH    8
`define BRIDGE_ADDR_WIDTH    3

// Almost flags, compared against occupancy
`define BRIDGE_AFULL_LEVEL   6
`define BRIDGE_AEMPTY_LEVEL  1

////////////////////////////////////////////////////////////
// Register map, word addresses
////////////////////////////////////////////////////////////
`define BRIDGE_REG_DATA      0
`define BRIDGE_REG_STATUS    1
`define BRIDGE_REG_CLEAR     2

`endif

// ==== verilog/bridge_bus_pkg.sv ====
package bridge_bus_pkg;

    typedef logic [3:0]  wb_addr_t; // Word address
    typedef logic [31:0] wb_word_t;

    typedef enum logic [1:0] {
        REG_DATA,
        REG_STATUS,
        REG_CLEAR,
        REG_NONE
    } reg_sel_t;

    ////////////////////////////////////////////////////////////
    // Status word bit positions
    ////////////////////////////////////////////////////////////
    localparam int STAT_TX_EMPTY        = 0;
    localparam int STAT_TX_FULL         = 1;
    localparam int STAT_TX_ALMOST_FULL  = 2;
    localparam int STAT_RX_EMPTY        = 3;
    localparam int STAT_RX_FULL         = 4;
    localparam int STAT_RX_ALMOST_EMPTY = 5;
    // Sticky, cleared through CLEAR
    localparam int STAT_TX_OVERFLOW     = 8;
    localparam int STAT_RX_UNDERFLOW    = 9;

endpackage

// ==== verilog/bridge_stream_pkg.sv ====
`include "stream_bridge_config.svh"

package bridge_stream_pkg;

    typedef logic [7:0] stream_byte_t;

    // One extra bit so a full FIFO is distinct from an empty one
    typedef logic [`BRIDGE_ADDR_WIDTH:0] fifo_count_t;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ns

`include "stream_bridge_config.svh"

module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push,
    input  logic [DATA_WIDTH-1:0]         push_data,
    input  logic                          pop,
    output logic [DATA_WIDTH-1:0]         head_data,
    output logic                          full,
    output logic                          empty,
    output logic                          almost_full,
    output logic                          almost_empty,
    output logic                          overflow,
    output logic                          underflow,
    output bridge_stream_pkg::fifo_count_t count
);

    import bridge_stream_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam fifo_count_t DEPTH_CNT  = fifo_count_t'(FIFO_DEPTH);
    localparam fifo_count_t AFULL_LVL  = fifo_count_t'(`BRIDGE_AFULL_LEVEL);
    localparam fifo_count_t AEMPTY_LVL = fifo_count_t'(`BRIDGE_AEMPTY_LEVEL);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    fifo_count_t           count_q;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    assign head_data = mem[rd_ptr]; // Show-ahead

    assign full         = (count_q == DEPTH_CNT);
    assign empty        = (count_q == '0);
    assign almost_full  = (count_q >= AFULL_LVL);
    assign almost_empty = (count_q <= AEMPTY_LVL);

    // Refused requests, high only in the request cycle
    assign overflow  = push && full;
    assign underflow = pop && empty;

    assign count = count_q;

endmodule

// ==== verilog/bridge_ctrl.sv ====
`timescale 1ns/1ns

`include "stream_bridge_config.svh"

module bridge_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    // Wishbone classic slave
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  bridge_bus_pkg::wb_addr_t        adr,
    input  bridge_bus_pkg::wb_word_t        dat_w,
    output bridge_bus_pkg::wb_word_t        dat_r,
    output logic                            ack,
    // TX FIFO side
    input  logic                            tx_full,
    input  logic                            tx_empty,
    input  logic                            tx_almost_full,
    input  logic                            tx_overflow,
    output logic                            tx_push,
    output bridge_stream_pkg::stream_byte_t tx_push_data,
    // RX FIFO side
    input  logic                            rx_empty,
    input  logic                            rx_full,
    input  logic                            rx_almost_empty,
    input  logic                            rx_underflow,
    input  bridge_stream_pkg::stream_byte_t rx_head,
    output logic                            rx_pop
);

    import bridge_bus_pkg::*;

    reg_sel_t sel;
    logic     req;
    logic     data_wr;
    logic     data_rd;
    logic     clear_wr;
    logic     tx_ovf_sticky;
    logic     rx_unf_sticky;
    wb_word_t status_word;
    wb_word_t rd_word;

    ////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////
    assign req = cyc && stb && !ack; // New transfer

    always_comb begin
        case (adr)
            wb_addr_t'(`BRIDGE_REG_DATA):   sel = REG_DATA;
            wb_addr_t'(`BRIDGE_REG_STATUS): sel = REG_STATUS;
            wb_addr_t'(`BRIDGE_REG_CLEAR):  sel = REG_CLEAR;
            default:                        sel = REG_NONE;
        endcase
    end

    assign data_wr  = req && we && (sel == REG_DATA);
    assign data_rd  = req && !we && (sel == REG_DATA);
    assign clear_wr = req && we && (sel == REG_CLEAR);

    // FIFO decides whether the strobe is taken
    assign tx_push      = data_wr;
    assign tx_push_data = dat_w[7:0];
    assign rx_pop       = data_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ack <= 1'b0;
        else
            ack <= req;
    end

    ////////////////////////////////////////////////////////////
    // Sticky error bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_ovf_sticky <= 1'b0;
            rx_unf_sticky <= 1'b0;
        end else begin
            if (tx_overflow)
                tx_ovf_sticky <= 1'b1;
            else if (clear_wr && dat_w[STAT_TX_OVERFLOW])
                tx_ovf_sticky <= 1'b0;

            if (rx_underflow)
                rx_unf_sticky <= 1'b1;
            else if (clear_wr && dat_w[STAT_RX_UNDERFLOW])
                rx_unf_sticky <= 1'b0;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STAT_TX_EMPTY]        = tx_empty;
        status_word[STAT_TX_FULL]         = tx_full;
        status_word[STAT_TX_ALMOST_FULL]  = tx_almost_full;
        status_word[STAT_RX_EMPTY]        = rx_empty;
        status_word[STAT_RX_FULL]         = rx_full;
        status_word[STAT_RX_ALMOST_EMPTY] = rx_almost_empty;
        status_word[STAT_TX_OVERFLOW]     = tx_ovf_sticky;
        status_word[STAT_RX_UNDERFLOW]    = rx_unf_sticky;
    end

    ////////////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////////////
    always_comb begin
        rd_word = '0;
        if (!we) begin
            case (sel)
                REG_DATA:   rd_word = rx_underflow ? '0 : wb_word_t'(rx_head);
                REG_STATUS: rd_word = status_word;
                default:    rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dat_r <= '0;
        else if (req)
            dat_r <= rd_word; // Latched with the ack edge
    end

endmodule

// ==== verilog/stream_bridge_top.sv ====
`timescale 1ns/1ns

`include "stream_bridge_config.svh"

module stream_bridge_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cyc,
    input  logic                            stb,
    input  logic                            we,
    input  bridge_bus_pkg::wb_addr_t        adr,
    input  bridge_bus_pkg::wb_word_t        dat_w,
    output bridge_bus_pkg::wb_word_t        dat_r,
    output logic                            ack,
    output bridge_stream_pkg::stream_byte_t tx_data,
    output logic                            tx_valid,
    input  logic                            tx_ready,
    input  bridge_stream_pkg::stream_byte_t rx_data,
    input  logic                            rx_valid,
    output logic                            rx_ready
);

    import bridge_stream_pkg::*;

    logic         tx_push, tx_full, tx_empty, tx_almost_full, tx_overflow;
    logic         rx_pop, rx_full, rx_empty, rx_almost_empty, rx_underflow;
    stream_byte_t tx_push_data;
    stream_byte_t rx_head;

    bridge_ctrl ctrl0 (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack),
        .tx_full(tx_full), .tx_empty(tx_empty), .tx_almost_full(tx_almost_full),
        .tx_overflow(tx_overflow), .tx_push(tx_push), .tx_push_data(tx_push_data),
        .rx_empty(rx_empty), .rx_full(rx_full), .rx_almost_empty(rx_almost_empty),
        .rx_underflow(rx_underflow), .rx_head(rx_head), .rx_pop(rx_pop)
    );

    ////////////////////////////////////////////////////////////
    // TX path, drains onto the outgoing stream
    ////////////////////////////////////////////////////////////
    sync_fifo #(.DATA_WIDTH($bits(stream_byte_t)), .FIFO_DEPTH(`BRIDGE_FIFO_DEPTH)) tx_fifo0 (
        .clk(clk), .rst_n(rst_n),
        .push(tx_push), .push_data(tx_push_data), .pop(tx_ready),
        .head_data(tx_data), .full(tx_full), .empty(tx_empty),
        .almost_full(tx_almost_full), .almost_empty(),
        .overflow(tx_overflow), .underflow(), .count()
    );

    assign tx_valid = !tx_empty;

    // RX path, filled from the incoming stream
    sync_fifo #(.DATA_WIDTH($bits(stream_byte_t)), .FIFO_DEPTH(`BRIDGE_FIFO_DEPTH)) rx_fifo0 (
        .clk(clk), .rst_n(rst_n),
        .push(rx_valid), .push_data(rx_data), .pop(rx_pop),
        .head_data(rx_head), .full(rx_full), .empty(rx_empty),
        .almost_full(), .almost_empty(rx_almost_empty),
        .overflow(), .underflow(rx_underflow), .count()
    );

    assign rx_ready = !rx_full;

endmodule

// ==== tests/stream_bridge_tb.sv ====
`timescale 1ns/1ns

module stream_bridge_tb;

    import bridge_bus_pkg::*;
    import bridge_stream_pkg::*;

    localparam int BUS_TIMEOUT    = 20;
    localparam int STREAM_TIMEOUT = 50;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         cyc, stb, we;
    wb_addr_t     adr;
    wb_word_t     dat_w;
    wb_word_t     dat_r;
    logic         ack;
    stream_byte_t tx_data;
    logic         tx_valid, tx_ready;
    stream_byte_t rx_data;
    logic         rx_valid, rx_ready;

    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    test_err_base = 0;
    bit    timed_out = 1'b0;
    string cur_test = "";

    stream_bridge_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: %s expected %h, actual %h", cur_test, what, exp, got);
            errors++;
        end
    endtask

    task automatic flag_timeout(input string what);
        $display("Timeout in %s: %s", cur_test, what);
        errors++;
        timed_out = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and stream drivers start and end 1 ns past an edge
    ////////////////////////////////////////////////////////////
    task automatic bus_cycle(input logic write, input wb_addr_t a, input wb_word_t wdata,
                             output wb_word_t rdata);
        int n;
        n = 0;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = a;
        dat_w = wdata;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!ack && n < BUS_TIMEOUT);
        rdata = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        if (!ack)
            flag_timeout("no ack came back for a bus cycle");
        else begin
            check_value("ack delay in cycles", 32'd1, n);
            @(posedge clk); // Ack lasts one cycle
            #1;
            check_value("ack after its cycle", 32'h0, {31'h0, ack});
        end
    endtask

    task automatic send_byte(input stream_byte_t b);
        int n;
        n = 0;
        rx_data = b;
        rx_valid = 1'b1;
        while (!rx_ready && n < STREAM_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rx_ready)
            flag_timeout("rx_ready stayed low, byte not accepted");
        else begin
            @(posedge clk); // Handshake edge
            #1;
        end
        rx_valid = 1'b0;
    endtask

    task automatic take_byte(input stream_byte_t exp);
        int n;
        n = 0;
        tx_ready = 1'b1;
        while (!tx_valid && n < STREAM_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!tx_valid)
            flag_timeout("tx_valid never rose");
        else begin
            check_value("tx_data", {24'h0, exp}, {24'h0, tx_data});
            @(posedge clk);
            #1;
        end
        tx_ready = 1'b0;
    endtask

    task automatic hold_stream(input int cycles, input stream_byte_t exp);
        tx_ready = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            check_value("tx_valid under back-pressure", 32'h1, {31'h0, tx_valid});
            check_value("tx_data under back-pressure", {24'h0, exp}, {24'h0, tx_data});
        end
    endtask

    task automatic run_op(input string op, input logic [31:0] arg, input logic [31:0] val);
        wb_word_t rdata;
        if (op == "WR")
            bus_cycle(1'b1, wb_addr_t'(arg), val, rdata);
        else if (op == "RD") begin
            bus_cycle(1'b0, wb_addr_t'(arg), '0, rdata);
            if (!timed_out)
                check_value($sformatf("read of address %0h", arg), val, rdata);
        end else if (op == "SEND")
            send_byte(arg[7:0]);
        else if (op == "TAKE")
            take_byte(val[7:0]);
        else if (op == "HOLD")
            hold_stream(arg, val[7:0]);
        else if (op == "PIN") begin
            if (arg == 0)
                check_value("tx_valid", val, {31'h0, tx_valid});
            else
                check_value("rx_ready", val, {31'h0, rx_ready});
        end else begin
            $display("Unknown operation %s in the vector file", op);
            errors++;
        end
    endtask

    task automatic finish_test();
        $display("%s: done, %0d error(s)", cur_test, errors - test_err_base);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        int          code;
        int          c;
        bit          done;
        string       tname;
        string       op;
        logic [31:0] arg;
        logic [31:0] val;

        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        tx_ready = 1'b0;
        rx_data = '0;
        rx_valid = 1'b0;
        done = 1'b0;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        fd = $fopen("tests/stream_bridge_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tests/stream_bridge_vectors.txt");
            errors++;
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", tname);
                if (code != 1)
                    done = 1'b1; // End of file
                else if (tname == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1)
                        c = $fgetc(fd);
                end else begin
                    code = $fscanf(fd, "%s %h %h", op, arg, val);
                    if (code != 3) begin
                        $display("Vector file line for %s is incomplete", tname);
                        errors++;
                        done = 1'b1;
                    end else begin
                        if (tname != cur_test) begin
                            if (cur_test != "")
                                finish_test();
                            cur_test = tname;
                            test_err_base = errors;
                            tests++;
                        end
                        run_op(op, arg, val);
                        if (timed_out)
                            done = 1'b1;
                    end
                end
            end
            if (cur_test != "")
                finish_test();
            $fclose(fd);
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== tests/stream_bridge_vectors.txt ====
# test op arg value (hex). arg is an address, a byte, a cycle count or a pin (0 tx_valid, 1 rx_ready)
# value is the write data for WR and the expected result for RD, TAKE, HOLD and PIN
reset PIN 0 0
reset PIN 1 1
reset RD 1 00000029
tx_order WR 0 000000a1
tx_order WR 0 000000b2
tx_order WR 0 000000c3
tx_order PIN 0 1
tx_order TAKE 0 a1
tx_order TAKE 0 b2
tx_order TAKE 0 c3
tx_order PIN 0 0
tx_full WR 0 00000001
tx_full WR 0 00000002
tx_full WR 0 00000003
tx_full WR 0 00000004
tx_full WR 0 00000005
tx_full WR 0 00000006
tx_full WR 0 00000007
tx_full WR 0 00000008
tx_full RD 1 0000002e
tx_full WR 0 00000009
tx_full RD 1 0000012e
tx_full TAKE 0 01
tx_full TAKE 0 02
tx_full TAKE 0 03
tx_full TAKE 0 04
tx_full TAKE 0 05
tx_full TAKE 0 06
tx_full TAKE 0 07
tx_full TAKE 0 08
tx_full PIN 0 0
rx_full_order SEND 11 0
rx_full_order SEND 22 0
rx_full_order SEND 33 0
rx_full_order SEND 44 0
rx_full_order SEND 55 0
rx_full_order SEND 66 0
rx_full_order SEND 77 0
rx_full_order SEND 88 0
rx_full_order PIN 1 0
rx_full_order RD 1 00000111
rx_full_order RD 0 00000011
rx_full_order RD 0 00000022
rx_full_order RD 0 00000033
rx_full_order RD 0 00000044
rx_full_order RD 0 00000055
rx_full_order RD 0 00000066
rx_full_order RD 0 00000077
rx_full_order RD 1 00000121
rx_full_order RD 0 00000088
rx_full_order RD 1 00000129
underflow RD 0 00000000
underflow RD 1 00000329
underflow WR 2 00000300
underflow RD 1 00000029
backpressure WR 0 000000e1
backpressure WR 0 000000f2
backpressure HOLD 5 e1
backpressure TAKE 0 e1
backpressure TAKE 0 f2
backpressure PIN 0 0

// ==== filelist.f ====
+incdir+verilog
verilog/bridge_bus_pkg.sv
verilog/bridge_stream_pkg.sv
verilog/sync_fifo.sv
verilog/bridge_ctrl.sv
verilog/stream_bridge_top.sv
tests/stream_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: stream_bridge

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bridge_bus_pkg.sv
      - verilog/bridge_stream_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/bridge_ctrl.sv
      - verilog/stream_bridge_top.sv
  - target: test
    files:
      - tests/stream_bridge_tb.sv
